//--- compile.f
+incdir+include
hw/rv_core_pkg.sv
hw/pipe_ctrl_if.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/hazard_unit.sv
hw/rv_core_top.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module rv_core_tb
	./obj_dir/Vrv_core_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/rv_core_tb.sv
module rv_core_tb import rv_core_pkg::*; ();

  localparam int    RESET_CYCLES = 8;
  // six programs of up to 100 instructions, plus reset, stall and flush slack
  localparam int    TIMEOUT_CYCLES = 4000;
  localparam word_t LFSR_SEED = 32'hbc3e_5ace;
  localparam word_t LFSR_TAPS = 32'h8020_0003;
  localparam logic [11:0] MARKER = 12'h3fc;

  logic  clk;
  logic  reset_i;
  word_t boot_addr;
  word_t imem_addr;
  word_t imem_rdata;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_rd;
  logic  dmem_wr;
  word_t dmem_rdata;
  logic  fill_req;

  word_t imem [256];
  word_t dmem [256];
  // expected state, built from instruction semantics
  word_t xreg [32];
  word_t mexp [256];
  word_t prog [$];
  word_t prog_base;
  word_t lfsr;
  logic  rd_before_wr;
  int    checks;
  int    errors;

  rv_core_top rv_core_top_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .boot_addr_i  (boot_addr),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_rd_o    (dmem_rd),
    .dmem_wr_o    (dmem_wr),
    .dmem_rdata_i (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  function automatic word_t fill_word(input logic [7:0] idx);
    return {16'hc0de, 6'd0, idx, 2'b00};
  endfunction

  always @(posedge clk) begin
    if (fill_req) begin
      for (int i = 0; i < 256; i++) begin
        dmem[8'(i)] <= fill_word(8'(i));
      end
    end else if (dmem_wr) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic word_t lfsr_next(input word_t s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output word_t val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input reg_addr_t rs2, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // RV32I results for the supported funct3 codes
  function automatic word_t isa_result(input logic [2:0] f3, input logic is_sub,
                                       input word_t a, input word_t b);
    case (f3)
      3'b000:  return is_sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic set_reg(input reg_addr_t rd, input word_t v);
    if (rd != 5'd0) begin
      xreg[rd] = v;
    end
  endtask

  task automatic emit(input word_t instr);
    prog.push_back(instr);
  endtask

  task automatic arith_rr(input logic [2:0] f3, input logic is_sub, input reg_addr_t rd,
                          input reg_addr_t rs1, input reg_addr_t rs2);
    emit(r_type(is_sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd));
    set_reg(rd, isa_result(f3, is_sub, xreg[rs1], xreg[rs2]));
  endtask

  task automatic imm_alu(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                         input logic [11:0] imm);
    emit(i_type(OPC_OP_IMM, f3, rd, rs1, imm));
    set_reg(rd, isa_result(f3, 1'b0, xreg[rs1], {{20{imm[11]}}, imm}));
  endtask

  task automatic lui_write(input reg_addr_t rd, input logic [19:0] imm);
    emit(u_type(rd, imm));
    set_reg(rd, {imm, 12'h000});
  endtask

  // lui then addi, upper part rounded for the signed low half
  task automatic const_to_reg(input reg_addr_t rd, input word_t v);
    logic [19:0] hi;
    hi = v[31:12] + {19'd0, v[11]};
    lui_write(rd, hi);
    imm_alu(3'b000, rd, rd, v[11:0]);
  endtask

  task automatic store_word(input reg_addr_t rs2, input logic [11:0] addr);
    emit(s_type(rs2, 5'd0, addr));
    mexp[addr[9:2]] = xreg[rs2];
  endtask

  task automatic load_word(input reg_addr_t rd, input logic [11:0] addr);
    emit(i_type(OPC_LOAD, 3'b010, rd, 5'd0, addr));
    set_reg(rd, mexp[addr[9:2]]);
  endtask

  task automatic link_jump(input reg_addr_t rd, input logic [20:0] off);
    set_reg(rd, prog_base + 32'(4 * prog.size()) + 32'd4);
    emit(j_type(rd, off));
  endtask

  task automatic new_program(input word_t base);
    prog.delete();
    prog_base = base;
    for (int k = 0; k < 32; k++) begin
      xreg[5'(k)] = 'x;
    end
    xreg[0] = '0;
    for (int k = 0; k < 256; k++) begin
      mexp[8'(k)] = fill_word(8'(k));
    end
  endtask

  task automatic restart_core();
    @(posedge clk);
    reset_i   <= 1'b1;
    boot_addr <= prog_base;
    fill_req  <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    // rom filler is addi x0, x0, <byte address>
    for (int k = 0; k < 256; k++) begin
      imem[8'(k)] = i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, {2'b00, 8'(k), 2'b00});
    end
    foreach (prog[k]) begin
      imem[prog_base[9:2] + 8'(k)] = prog[k];
    end
    fill_req <= 1'b0;
    reset_i  <= 1'b0;
  endtask

  task automatic run_to_marker();
    logic seen_wr;
    logic done;
    seen_wr      = 1'b0;
    done         = 1'b0;
    rd_before_wr = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (dmem_rd && !seen_wr) begin
        rd_before_wr = 1'b1;
      end
      if (dmem_wr) begin
        seen_wr = 1'b1;
        done    = (dmem_addr == {20'd0, MARKER});
      end
    end
    // let the marker store land
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s address is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic verify_dmem();
    for (int i = 0; i < 256; i++) begin
      check_word($sformatf("dmem[0x%03h]", 4 * i), dmem[8'(i)], mexp[8'(i)]);
    end
  endtask

  task automatic boot_and_strobes();
    word_t a;
    rand_bits(32, a);
    new_program(32'h0000_0200);
    const_to_reg(5'd1, a);
    store_word(5'd1, 12'h040);
    store_word(5'd0, MARKER);
    restart_core();
    @(negedge clk);
    check_addr("first fetch", imem_addr, prog_base);
    run_to_marker();
    checks++;
    if (rd_before_wr) begin
      errors++;
      $display("data-memory read strobe seen before the first store at %0t", $time);
    end
    verify_dmem();
  endtask

  task automatic forwarding_chain();
    word_t a;
    word_t b;
    word_t sh;
    word_t imm;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(5, sh);
    rand_bits(12, imm);
    new_program(32'h0000_0000);
    const_to_reg(5'd1, a);
    const_to_reg(5'd2, b);
    arith_rr(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
    arith_rr(3'b000, 1'b1, 5'd4, 5'd3, 5'd1);
    arith_rr(3'b111, 1'b0, 5'd5, 5'd4, 5'd3);
    arith_rr(3'b110, 1'b0, 5'd6, 5'd5, 5'd2);
    arith_rr(3'b100, 1'b0, 5'd7, 5'd6, 5'd5);
    arith_rr(3'b010, 1'b0, 5'd8, 5'd7, 5'd1);
    imm_alu(3'b000, 5'd9, 5'd0, {7'd0, sh[4:0]});
    arith_rr(3'b001, 1'b0, 5'd10, 5'd7, 5'd9);
    arith_rr(3'b101, 1'b0, 5'd11, 5'd10, 5'd9);
    imm_alu(3'b000, 5'd12, 5'd11, imm[11:0]);
    imm_alu(3'b111, 5'd13, 5'd12, imm[11:0]);
    imm_alu(3'b110, 5'd14, 5'd13, imm[11:0]);
    imm_alu(3'b100, 5'd15, 5'd14, imm[11:0]);
    imm_alu(3'b010, 5'd16, 5'd15, imm[11:0]);
    for (int r = 3; r <= 16; r++) begin
      store_word(5'(r), 12'(256 + 4 * r));
    end
    store_word(5'd0, MARKER);
    restart_core();
    run_to_marker();
    verify_dmem();
  endtask

  task automatic load_use_stall();
    word_t a;
    word_t b;
    rand_bits(32, a);
    rand_bits(32, b);
    new_program(32'h0000_0000);
    const_to_reg(5'd1, a);
    const_to_reg(5'd2, b);
    store_word(5'd1, 12'h080);
    load_word(5'd3, 12'h080);
    arith_rr(3'b000, 1'b0, 5'd4, 5'd3, 5'd2);
    store_word(5'd4, 12'h084);
    load_word(5'd5, 12'h0c0);
    arith_rr(3'b000, 1'b1, 5'd6, 5'd2, 5'd5);
    store_word(5'd6, 12'h088);
    // store data straight from a load
    load_word(5'd7, 12'h084);
    store_word(5'd7, 12'h08c);
    store_word(5'd0, MARKER);
    restart_core();
    run_to_marker();
    verify_dmem();
  endtask

  task automatic branch_flush();
    word_t a;
    rand_bits(32, a);
    new_program(32'h0000_0000);
    const_to_reg(5'd1, a);
    imm_alu(3'b100, 5'd2, 5'd1, 12'h001);
    // beq taken, two dead stores
    emit(b_type(3'b000, 5'd1, 5'd1, 13'd12));
    emit(s_type(5'd1, 5'd0, 12'h180));
    emit(s_type(5'd1, 5'd0, 12'h184));
    store_word(5'd1, 12'h188);
    emit(b_type(3'b000, 5'd1, 5'd2, 13'd8));
    store_word(5'd2, 12'h18c);
    store_word(5'd1, 12'h190);
    // bne taken
    emit(b_type(3'b001, 5'd1, 5'd2, 13'd12));
    emit(s_type(5'd2, 5'd0, 12'h194));
    emit(s_type(5'd2, 5'd0, 12'h198));
    store_word(5'd2, 12'h19c);
    emit(b_type(3'b001, 5'd2, 5'd2, 13'd8));
    store_word(5'd1, 12'h1a0);
    store_word(5'd2, 12'h1a4);
    store_word(5'd0, MARKER);
    restart_core();
    run_to_marker();
    verify_dmem();
  endtask

  task automatic jal_and_x0();
    word_t a;
    rand_bits(32, a);
    new_program(32'h0000_0000);
    const_to_reg(5'd1, a);
    link_jump(5'd5, 21'd12);
    emit(s_type(5'd1, 5'd0, 12'h200));
    emit(s_type(5'd1, 5'd0, 12'h204));
    store_word(5'd5, 12'h208);
    imm_alu(3'b000, 5'd0, 5'd1, 12'h5a5);
    store_word(5'd0, 12'h20c);
    lui_write(5'd0, 20'habcde);
    store_word(5'd0, 12'h210);
    link_jump(5'd0, 21'd8);
    emit(s_type(5'd1, 5'd0, 12'h214));
    store_word(5'd1, 12'h218);
    store_word(5'd0, MARKER);
    restart_core();
    run_to_marker();
    verify_dmem();
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no marker store within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    reset_i   = 1'b1;
    boot_addr = '0;
    fill_req  = 1'b0;
    lfsr      = LFSR_SEED;
    checks    = 0;
    errors    = 0;
    boot_and_strobes();
    forwarding_chain();
    forwarding_chain();
    load_use_stall();
    branch_flush();
    jal_and_x0();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb/rv_core_sva.sv
module rv_core_sva import rv_core_pkg::*; (
  input logic  clk,
  input logic  reset_i,
  input logic  dmem_rd_i,
  input logic  dmem_wr_i,
  input word_t imem_addr_i
);

  strobe_excl: assert property (@(posedge clk) disable iff (reset_i)
                                !(dmem_rd_i && dmem_wr_i))
    else $error("data-memory read and write strobes high together");

  // pipeline registers clear one edge after reset rises
  strobe_reset: assert property (@(posedge clk)
                                 (reset_i && $past(reset_i)) |-> !(dmem_rd_i || dmem_wr_i))
    else $error("data-memory strobe high during reset");

  pc_align: assert property (@(posedge clk) disable iff (reset_i)
                             imem_addr_i[1:0] == 2'b00)
    else $error("misaligned fetch address %h", imem_addr_i);

endmodule

bind rv_core_top rv_core_sva rv_core_sva_inst (
  .clk         (clk),
  .reset_i     (reset_i),
  .dmem_rd_i   (dmem_rd_o),
  .dmem_wr_i   (dmem_wr_o),
  .imem_addr_i (imem_addr_o)
);

//--- hw/rv_core_top.sv
module rv_core_top import rv_core_pkg::*; (
  input  logic  clk,
  input  logic  reset_i,
  input  word_t boot_addr_i,
  output word_t imem_addr_o,
  input  word_t imem_rdata_i,
  output word_t dmem_addr_o,
  output word_t dmem_wdata_o,
  output logic  dmem_rd_o,
  output logic  dmem_wr_o,
  input  word_t dmem_rdata_i
);

  word_t     if_pc;
  word_t     if_instr;
  logic      redirect;
  word_t     target;
  ctrl_t     id_ctrl;
  word_t     id_rs1_data;
  word_t     id_rs2_data;
  word_t     id_imm;
  word_t     id_pc;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  reg_addr_t id_rd;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  ctrl_t     ex_ctrl;
  word_t     ex_result;
  word_t     ex_store;
  word_t     ex_pc4;
  reg_addr_t ex_rd;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  pipe_ctrl_if pipe_ctrl ();

  fetch_stage fetch_stage_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .boot_addr_i  (boot_addr_i),
    .redirect_i   (redirect),
    .target_i     (target),
    .imem_rdata_i (imem_rdata_i),
    .ctrl         (pipe_ctrl.fetch),
    .imem_addr_o  (imem_addr_o),
    .if_pc_o      (if_pc),
    .if_instr_o   (if_instr)
  );

  decode_stage decode_stage_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .pc_i          (if_pc),
    .instr_i       (if_instr),
    .wb_en_i       (wb_en),
    .wb_addr_i     (wb_addr),
    .wb_data_i     (wb_data),
    .ctrl          (pipe_ctrl.decode),
    .id_ctrl_o     (id_ctrl),
    .id_rs1_data_o (id_rs1_data),
    .id_rs2_data_o (id_rs2_data),
    .id_imm_o      (id_imm),
    .id_pc_o       (id_pc),
    .id_rs1_o      (id_rs1),
    .id_rs2_o      (id_rs2),
    .id_rd_o       (id_rd),
    .dec_rs1_o     (dec_rs1),
    .dec_rs2_o     (dec_rs2)
  );

  execute_stage execute_stage_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .id_ctrl_i     (id_ctrl),
    .id_rs1_data_i (id_rs1_data),
    .id_rs2_data_i (id_rs2_data),
    .id_imm_i      (id_imm),
    .id_pc_i       (id_pc),
    .id_rd_i       (id_rd),
    .mem_fwd_i     (wb_data),
    .ctrl          (pipe_ctrl.execute),
    .redirect_o    (redirect),
    .target_o      (target),
    .ex_ctrl_o     (ex_ctrl),
    .ex_result_o   (ex_result),
    .ex_store_o    (ex_store),
    .ex_pc4_o      (ex_pc4),
    .ex_rd_o       (ex_rd)
  );

  mem_wb_stage mem_wb_stage_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .ex_ctrl_i    (ex_ctrl),
    .ex_result_i  (ex_result),
    .ex_store_i   (ex_store),
    .ex_pc4_i     (ex_pc4),
    .ex_rd_i      (ex_rd),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_rd_o    (dmem_rd_o),
    .dmem_wr_o    (dmem_wr_o),
    .wb_en_o      (wb_en),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data)
  );

  hazard_unit hazard_unit_inst (
    .dec_rs1_i      (dec_rs1),
    .dec_rs2_i      (dec_rs2),
    .id_rs1_i       (id_rs1),
    .id_rs2_i       (id_rs2),
    .id_rd_i        (id_rd),
    .ex_rd_i        (ex_rd),
    .wb_addr_i      (wb_addr),
    .id_mem_rd_i    (id_ctrl.mem_rd),
    .ex_reg_write_i (ex_ctrl.reg_write),
    .wb_en_i        (wb_en),
    .redirect_i     (redirect),
    .ctrl           (pipe_ctrl.unit)
  );

endmodule

//--- hw/hazard_unit.sv
module hazard_unit import rv_core_pkg::*; (
  input  reg_addr_t dec_rs1_i,
  input  reg_addr_t dec_rs2_i,
  input  reg_addr_t id_rs1_i,
  input  reg_addr_t id_rs2_i,
  input  reg_addr_t id_rd_i,
  input  reg_addr_t ex_rd_i,
  input  reg_addr_t wb_addr_i,
  input  logic      id_mem_rd_i,
  input  logic      ex_reg_write_i,
  input  logic      wb_en_i,
  input  logic      redirect_i,
  pipe_ctrl_if.unit ctrl
);

  // EX/MEM wins over MEM/WB
  function automatic fwd_sel_e pick_src(reg_addr_t src, reg_addr_t ex_rd, logic ex_we,
                                        reg_addr_t wb_rd, logic wb_we);
    if (src == '0) begin
      return FWD_RF;
    end
    if (ex_we && (ex_rd == src)) begin
      return FWD_EXMEM;
    end
    if (wb_we && (wb_rd == src)) begin
      return FWD_MEMWB;
    end
    return FWD_RF;
  endfunction

  assign ctrl.fwd_a = pick_src(id_rs1_i, ex_rd_i, ex_reg_write_i, wb_addr_i, wb_en_i);
  assign ctrl.fwd_b = pick_src(id_rs2_i, ex_rd_i, ex_reg_write_i, wb_addr_i, wb_en_i);

  // load-use, one bubble
  assign ctrl.stall = id_mem_rd_i && (id_rd_i != '0) &&
                      ((id_rd_i == dec_rs1_i) || (id_rd_i == dec_rs2_i));

  assign ctrl.flush_if_id = redirect_i;
  assign ctrl.flush_id_ex = redirect_i;

endmodule

//--- hw/mem_wb_stage.sv
module mem_wb_stage import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  ctrl_t     ex_ctrl_i,
  input  word_t     ex_result_i,
  input  word_t     ex_store_i,
  input  word_t     ex_pc4_i,
  input  reg_addr_t ex_rd_i,
  input  word_t     dmem_rdata_i,
  output word_t     dmem_addr_o,
  output word_t     dmem_wdata_o,
  output logic      dmem_rd_o,
  output logic      dmem_wr_o,
  output logic      wb_en_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o
);

  wb_sel_e wb_sel_q;
  word_t   alu_q;
  word_t   load_q;
  word_t   pc4_q;

  assign dmem_addr_o  = ex_result_i;
  assign dmem_wdata_o = ex_store_i;
  assign dmem_rd_o    = ex_ctrl_i.mem_rd;
  assign dmem_wr_o    = ex_ctrl_i.mem_wr;

  // MEM/WB
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_en_o  <= 1'b0;
      wb_sel_q <= WB_ALU;
    end else begin
      wb_en_o  <= ex_ctrl_i.reg_write;
      wb_sel_q <= ex_ctrl_i.wb_sel;
    end
  end

  always_ff @(posedge clk) begin
    alu_q     <= ex_result_i;
    load_q    <= dmem_rdata_i;
    pc4_q     <= ex_pc4_i;
    wb_addr_o <= ex_rd_i;
  end

  // also the MEM/WB forward source
  always_comb begin
    case (wb_sel_q)
      WB_MEM:  wb_data_o = load_q;
      WB_PC4:  wb_data_o = pc4_q;
      default: wb_data_o = alu_q;
    endcase
  end

endmodule

//--- hw/execute_stage.sv
module execute_stage import rv_core_pkg::*; (
  input  logic         clk,
  input  logic         reset_i,
  input  ctrl_t        id_ctrl_i,
  input  word_t        id_rs1_data_i,
  input  word_t        id_rs2_data_i,
  input  word_t        id_imm_i,
  input  word_t        id_pc_i,
  input  reg_addr_t    id_rd_i,
  input  word_t        mem_fwd_i,
  pipe_ctrl_if.execute ctrl,
  output logic         redirect_o,
  output word_t        target_o,
  output ctrl_t        ex_ctrl_o,
  output word_t        ex_result_o,
  output word_t        ex_store_o,
  output word_t        ex_pc4_o,
  output reg_addr_t    ex_rd_o
);

  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_out;
  word_t exmem_fwd;

  // jal in EX/MEM forwards its link address
  assign exmem_fwd = (ex_ctrl_o.wb_sel == WB_PC4) ? ex_pc4_o : ex_result_o;

  always_comb begin
    case (ctrl.fwd_a)
      FWD_EXMEM: op_a = exmem_fwd;
      FWD_MEMWB: op_a = mem_fwd_i;
      default:   op_a = id_rs1_data_i;
    endcase
    case (ctrl.fwd_b)
      FWD_EXMEM: rs2_val = exmem_fwd;
      FWD_MEMWB: rs2_val = mem_fwd_i;
      default:   rs2_val = id_rs2_data_i;
    endcase
  end

  assign op_b = id_ctrl_i.use_imm ? id_imm_i : rs2_val;

  always_comb begin
    case (id_ctrl_i.alu_op)
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLL:    alu_out = op_a << op_b[4:0];
      ALU_SRL:    alu_out = op_a >> op_b[4:0];
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // branch compare uses the register operands, not the immediate
  assign redirect_o = id_ctrl_i.jump |
                      (id_ctrl_i.branch & ((op_a == rs2_val) ^ id_ctrl_i.branch_ne));
  assign target_o   = id_pc_i + id_imm_i;

  // EX/MEM
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_ctrl_o <= CTRL_NOP;
    end else begin
      ex_ctrl_o <= id_ctrl_i;
    end
  end

  always_ff @(posedge clk) begin
    ex_result_o <= alu_out;
    ex_store_o  <= rs2_val;
    ex_pc4_o    <= id_pc_i + 32'd4;
    ex_rd_o     <= id_rd_i;
  end

endmodule

//--- hw/decode_stage.sv
`include "rv_core_macros.svh"

module decode_stage import rv_core_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  word_t       pc_i,
  input  word_t       instr_i,
  input  logic        wb_en_i,
  input  reg_addr_t   wb_addr_i,
  input  word_t       wb_data_i,
  pipe_ctrl_if.decode ctrl,
  output ctrl_t       id_ctrl_o,
  output word_t       id_rs1_data_o,
  output word_t       id_rs2_data_o,
  output word_t       id_imm_o,
  output word_t       id_pc_o,
  output reg_addr_t   id_rs1_o,
  output reg_addr_t   id_rs2_o,
  output reg_addr_t   id_rd_o,
  output reg_addr_t   dec_rs1_o,
  output reg_addr_t   dec_rs2_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_d;
  ctrl_t      ctrl_d;
  word_t      rs1_data;
  word_t      rs2_data;

  assign opcode    = instr_i[`OPC_R];
  assign funct3    = instr_i[`F3_R];
  assign funct7    = instr_i[`F7_R];
  assign rd        = instr_i[`RD_R];
  assign dec_rs1_o = instr_i[`RS1_R];
  assign dec_rs2_o = instr_i[`RS2_R];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    ctrl_d = CTRL_NOP;
    imm_d  = imm_i;
    case (opcode)
      OPC_OP: begin
        ctrl_d.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl_d.alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl_d.alu_op = ALU_SLL;
          3'b010:  ctrl_d.alu_op = ALU_SLT;
          3'b100:  ctrl_d.alu_op = ALU_XOR;
          3'b101:  ctrl_d.alu_op = ALU_SRL;
          3'b110:  ctrl_d.alu_op = ALU_OR;
          3'b111:  ctrl_d.alu_op = ALU_AND;
          default: ctrl_d = CTRL_NOP;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl_d.reg_write = 1'b1;
        ctrl_d.use_imm   = 1'b1;
        case (funct3)
          3'b000:  ctrl_d.alu_op = ALU_ADD;
          3'b010:  ctrl_d.alu_op = ALU_SLT;
          3'b100:  ctrl_d.alu_op = ALU_XOR;
          3'b110:  ctrl_d.alu_op = ALU_OR;
          3'b111:  ctrl_d.alu_op = ALU_AND;
          default: ctrl_d = CTRL_NOP;
        endcase
      end
      OPC_LUI: begin
        ctrl_d.alu_op    = ALU_PASS_B;
        ctrl_d.use_imm   = 1'b1;
        ctrl_d.reg_write = 1'b1;
        imm_d            = imm_u;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          ctrl_d.use_imm   = 1'b1;
          ctrl_d.reg_write = 1'b1;
          ctrl_d.mem_rd    = 1'b1;
          ctrl_d.wb_sel    = WB_MEM;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl_d.use_imm = 1'b1;
          ctrl_d.mem_wr  = 1'b1;
        end
        imm_d = imm_s;
      end
      OPC_BRANCH: begin
        // beq and bne only
        ctrl_d.branch    = (funct3[2:1] == 2'b00);
        ctrl_d.branch_ne = funct3[0];
        imm_d            = imm_b;
      end
      OPC_JAL: begin
        ctrl_d.jump      = 1'b1;
        ctrl_d.reg_write = 1'b1;
        ctrl_d.wb_sel    = WB_PC4;
        imm_d            = imm_j;
      end
      default: ctrl_d = CTRL_NOP;
    endcase
  end

  reg_file reg_file_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_i      (dec_rs1_o),
    .rs2_i      (dec_rs2_o),
    .wr_addr_i  (wb_addr_i),
    .wr_en_i    (wb_en_i),
    .wr_data_i  (wb_data_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // ID/EX, bubble on stall or flush
  always_ff @(posedge clk) begin
    if (reset_i || ctrl.stall || ctrl.flush_id_ex) begin
      id_ctrl_o <= CTRL_NOP;
    end else begin
      id_ctrl_o <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    id_rs1_data_o <= rs1_data;
    id_rs2_data_o <= rs2_data;
    id_imm_o      <= imm_d;
    id_pc_o       <= pc_i;
    id_rs1_o      <= dec_rs1_o;
    id_rs2_o      <= dec_rs2_o;
    id_rd_o       <= rd;
  end

endmodule

//--- hw/fetch_stage.sv
module fetch_stage import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              reset_i,
  input  word_t             boot_addr_i,
  input  logic              redirect_i,
  input  word_t             target_i,
  input  word_t             imem_rdata_i,
  pipe_ctrl_if.fetch        ctrl,
  output word_t             imem_addr_o,
  output word_t             if_pc_o,
  output word_t             if_instr_o
);

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  word_t pc_q;
  word_t pc_d;

  always_comb begin
    if (redirect_i) begin
      pc_d = target_i;
    end else if (ctrl.stall) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= boot_addr_i;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign imem_addr_o = pc_q;

  // IF/ID
  always_ff @(posedge clk) begin
    if (reset_i || ctrl.flush_if_id) begin
      if_instr_o <= NOP_INSTR;
    end else if (!ctrl.stall) begin
      if_instr_o <= imem_rdata_i;
      if_pc_o    <= pc_q;
    end
  end

endmodule

//--- hw/reg_file.sv
`include "rv_core_macros.svh"

module reg_file import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t wr_addr_i,
  input  logic      wr_en_i,
  input  word_t     wr_data_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  word_t regs [`NREGS];
  logic  we;

  // x0 is never written
  assign we = wr_en_i && !reset_i && (wr_addr_i != '0);

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // write-first bypass
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (we && (wr_addr_i == rs1_i)) begin
      rs1_data_o = wr_data_i;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
  end

  always_comb begin
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (we && (wr_addr_i == rs2_i)) begin
      rs2_data_o = wr_data_i;
    end else begin
      rs2_data_o = regs[rs2_i];
    end
  end

endmodule

//--- hw/pipe_ctrl_if.sv
interface pipe_ctrl_if import rv_core_pkg::*; ();

  logic     stall;
  logic     flush_if_id;
  logic     flush_id_ex;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  modport unit (
    output stall, flush_if_id, flush_id_ex, fwd_a, fwd_b
  );

  modport fetch (input stall, flush_if_id);

  modport decode (input stall, flush_id_ex);

  modport execute (input fwd_a, fwd_b);

endinterface

//--- hw/rv_core_pkg.sv
`include "rv_core_macros.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`RA_W-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [1:0] {
    FWD_RF,
    FWD_EXMEM,
    FWD_MEMWB
  } fwd_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    reg_write;
    logic    mem_rd;
    logic    mem_wr;
    logic    branch;
    logic    branch_ne;
    logic    jump;
    wb_sel_e wb_sel;
  } ctrl_t;

  // all zero is a bubble
  localparam ctrl_t CTRL_NOP = '0;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

//--- include/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and address width
`define XLEN 32
`define NREGS 32
`define RA_W 5

// instruction field positions
`define OPC_R 6:0
`define RD_R 11:7
`define F3_R 14:12
`define RS1_R 19:15
`define RS2_R 24:20
`define F7_R 31:25

`endif
